// ==== tb.f ====
+incdir+.
riscv_defines.sv
ex_types_pkg.sv
imm_gen.sv
alu.sv
mdu.sv
ex_stage.sv
ex_unit.sv
tb_ex_unit.sv

// ==== Makefile ====
# Verilator build and run of the execute-unit testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_unit
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(wildcard *.sv *.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_ex_ref.svh ====
`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

// Expected execute-unit response, worked out from the RV32IM rules

// RV32I register/immediate operations
function automatic word_t alu_model(input logic [3:0] op, input word_t a, input word_t b);
	case (alu_op_e'(op))
		ALU_ADD:  return a + b;
		ALU_SUB:  return a - b;
		ALU_SLL:  return a << b[4:0];
		ALU_SLT:  return word_t'($signed(a) < $signed(b));
		ALU_SLTU: return word_t'(a < b);
		ALU_XOR:  return a ^ b;
		ALU_SRL:  return a >> b[4:0];
		ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
		ALU_OR:   return a | b;
		ALU_AND:  return a & b;
		default:  return a + b;
	endcase
endfunction

// M extension with the spec's divide corner cases
function automatic word_t mdu_model(input logic [2:0] op, input word_t a, input word_t b);
	logic [63:0] ss; // signed x signed
	logic [63:0] su; // signed x unsigned
	logic [63:0] uu;
	logic        ovf;
	int          sa;
	int          sb;
	ss  = {{32{a[31]}}, a} * {{32{b[31]}}, b};
	su  = {{32{a[31]}}, a} * {32'b0, b};
	uu  = {32'b0, a} * {32'b0, b};
	ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
	sa  = a;
	sb  = b;
	case (mdu_op_e'(op))
		MDU_MUL:    return uu[31:0];
		MDU_MULH:   return ss[63:32];
		MDU_MULHSU: return su[63:32];
		MDU_MULHU:  return uu[63:32];
		MDU_DIV: begin
			if (b == '0) return '1;      // Quotient of x/0
			if (ovf) return a;
			return word_t'(sa / sb);     // Truncates toward zero
		end
		MDU_DIVU: begin
			if (b == '0) return '1;
			return a / b;
		end
		MDU_REM: begin
			if (b == '0) return a;       // x%0 is the dividend
			if (ovf) return '0;
			return word_t'(sa % sb);     // Sign of the dividend
		end
		default: begin               // REMU
			if (b == '0) return a;
			return a % b;
		end
	endcase
endfunction

function automatic ex_rsp_t expected_rsp(input ex_req_t req);
	word_t   i_imm;
	word_t   s_imm;
	word_t   u_imm;
	word_t   b_imm;
	word_t   j_imm;
	word_t   op_a;
	word_t   op_b;
	word_t   res;
	ex_rsp_t rsp;
	i_imm = word_t'($signed(req.instr) >>> 20);
	s_imm = {i_imm[31:5], req.instr[11:7]};       // Top seven bits shared with I
	u_imm = req.instr & 32'hffff_f000;
	b_imm = {{20{req.instr[31]}}, req.instr[7], req.instr[30:25], req.instr[11:8], 1'b0};
	j_imm = {{12{req.instr[31]}}, req.instr[19:12], req.instr[20], req.instr[30:21], 1'b0};
	op_a  = req.ctrl.auipc ? req.pc : req.rs1_data;
	if (!req.ctrl.imm_sel) op_b = req.rs2_data;
	else if (req.ctrl.auipc) op_b = u_imm;
	else op_b = req.ctrl.stype_imm_sel ? s_imm : i_imm;
	res = req.ctrl.mdu_sel ? mdu_model(req.ctrl.op[2:0], op_a, op_b)
		: alu_model(req.ctrl.op, op_a, op_b);
	if (req.ctrl.lui_bypass) rsp.wb_data = u_imm;
	else if (req.ctrl.jal || req.ctrl.jalr) rsp.wb_data = req.pc + 32'd4; // Link value
	else rsp.wb_data = res;
	rsp.rd_addr = req.instr[11:7];
	if (req.ctrl.jalr) rsp.branch_addr = req.pc + i_imm;
	else if (req.ctrl.jal) rsp.branch_addr = req.pc + j_imm;
	else rsp.branch_addr = req.pc + b_imm;
	rsp.branch_taken = (req.ctrl.branch && ((res == '0) ^ req.ctrl.zero_inv))
		|| req.ctrl.jal || req.ctrl.jalr;
	return rsp;
endfunction

`endif

// ==== tb_ex_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_unit import riscv_defines::*, ex_types_pkg::*;;

	localparam int RESET_CYCLES = 2;
	localparam int REPS         = 4; // Random requests per operation
	localparam int N_REQ        = 10*REPS + (9*2 + 3*REPS) + (6*3 + 6) + (8*REPS + 14);
	localparam int CYCLE_LIMIT  = N_REQ * (MDU_CYCLES + 10) + RESET_CYCLES;

	logic    clk_i;
	logic    arst_n_i;
	logic    req_i;
	ex_req_t req_data_i;
	logic    ack_o;
	ex_rsp_t rsp_o;

	int      seed = 32'h6af1_c453;
	int      pass_cnt;
	int      fail_cnt;
	int      err_start;   // Failures before the running test
	int      n_req;
	int      cycle_cnt;
	ex_rsp_t exp_q[$];    // Expected responses in issue order
	string   name_q[$];
	ex_rsp_t chk_exp;
	string   chk_name;
	logic    ack_q;

	`include "tb_ex_ref.svh"

	ex_unit ex_unit_inst (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.req_i      (req_i),
		.req_data_i (req_data_i),
		.ack_o      (ack_o),
		.rsp_o      (rsp_o)
	);

	always #2 clk_i = ~clk_i; // 4 ns period

	//////////////////////
	// Compare tasks
	//////////////////////

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h actual %h", name, exp, act);
			fail_cnt++;
		end else pass_cnt++;
	endtask

	task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %0d actual %0d", name, exp, act);
			fail_cnt++;
		end else pass_cnt++;
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %b actual %b", name, exp, act);
			fail_cnt++;
		end else pass_cnt++;
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[ERROR] %s: expected %0d cycles actual %0d cycles", name, exp, act);
			fail_cnt++;
		end else pass_cnt++;
	endtask

	task automatic check_rsp(input string name, input ex_rsp_t exp, input ex_rsp_t act);
		check_word({name, " wb_data"}, exp.wb_data, act.wb_data);
		check_addr({name, " rd_addr"}, exp.rd_addr, act.rd_addr);
		check_word({name, " branch_addr"}, exp.branch_addr, act.branch_addr);
		check_bit({name, " branch_taken"}, exp.branch_taken, act.branch_taken);
	endtask

	// Compare on each rise of ack_o at the falling clock edge
	always @(negedge clk_i) begin
		if (arst_n_i && ack_o && !ack_q) begin
			if (exp_q.size() == 0) begin
				$display("Acknowledge seen with no request outstanding");
				fail_cnt++;
			end else begin
				chk_exp  = exp_q.pop_front();
				chk_name = name_q.pop_front();
				check_rsp(chk_name, chk_exp, rsp_o);
			end
		end
		ack_q = ack_o;
	end

	// Watchdog
	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the unit stopped answering", cycle_cnt);
			$display("=== FAIL ===");
			$finish;
		end
	end

	//////////////////////
	// Stimulus
	//////////////////////

	function automatic word_t rand_word();
		return $random(seed);
	endfunction

	function automatic ex_req_t random_req();
		ex_req_t req;
		req.rs1_data = rand_word();
		req.rs2_data = rand_word();
		req.instr    = rand_word();
		req.pc       = rand_word() & 32'hffff_fffc; // Word aligned
		req.ctrl     = '0;
		return req;
	endfunction

	// Four-phase transfer entered 1 ns after a rising edge
	task automatic send_req(input string name, input ex_req_t req);
		ex_rsp_t rsp_exp;
		int      edges;
		int      hold;
		int      gap;
		gap = {$random(seed)} % 4;
		repeat (gap) begin // Idle gap before the request
			@(posedge clk_i);
			#1;
		end
		rsp_exp = expected_rsp(req);
		exp_q.push_back(rsp_exp);
		name_q.push_back(name);
		req_data_i = req;
		req_i      = 1'b1;
		edges      = 0;
		do begin
			@(posedge clk_i);
			#1;
			edges++;
		end while (!ack_o);
		if (!req.ctrl.mdu_sel) check_cycles({name, " latency"}, 2, edges); // Fixed path
		hold = {$random(seed)} % 6;
		repeat (hold) begin // Back-pressure
			@(posedge clk_i);
			#1;
			check_bit({name, " ack held"}, 1'b1, ack_o);
			check_rsp({name, " held"}, rsp_exp, rsp_o);
		end
		req_i = 1'b0;
		@(posedge clk_i);
		#1;
		check_bit({name, " ack fall"}, 1'b0, ack_o);
		n_req++;
	endtask

	task automatic begin_test();
		err_start = fail_cnt;
		n_req     = 0;
	endtask

	task automatic end_test(input string name);
		$display("test %-8s done, %0d requests, %0d errors", name, n_req, fail_cnt - err_start);
	endtask

	//////////////////////
	// Tests
	//////////////////////

	task automatic alu_reg_ops();
		ex_req_t req;
		begin_test();
		for (int op = 0; op < 10; op++) begin
			repeat (REPS) begin
				req         = random_req();
				req.ctrl.op = 4'(op);
				send_req("alu_reg", req);
			end
		end
		end_test("alu_reg");
	endtask

	task automatic imm_forms();
		alu_op_e i_ops [9] = '{ALU_ADD, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR, ALU_AND,
			ALU_SLL, ALU_SRL, ALU_SRA};
		ex_req_t req;
		begin_test();
		for (int i = 0; i < 9; i++) begin
			for (int s = 0; s < 2; s++) begin
				req               = random_req();
				req.instr[31]     = s[0];        // Immediate sign
				req.ctrl.op       = i_ops[i];
				req.ctrl.imm_sel  = 1'b1;
				send_req("imm_i", req);
			end
		end
		repeat (REPS) begin // Store address
			req                    = random_req();
			req.ctrl.imm_sel       = 1'b1;
			req.ctrl.stype_imm_sel = 1'b1;
			send_req("imm_s", req);
		end
		repeat (REPS) begin
			req                 = random_req();
			req.ctrl.lui_bypass = 1'b1;
			send_req("lui", req);
		end
		repeat (REPS) begin
			req              = random_req();
			req.ctrl.auipc   = 1'b1;
			req.ctrl.imm_sel = 1'b1;
			send_req("auipc", req);
		end
		end_test("imm");
	endtask

	task automatic branch_jump();
		alu_op_e br_op [6]   = '{ALU_SUB, ALU_SUB, ALU_SLT, ALU_SLT, ALU_SLTU, ALU_SLTU};
		logic    br_inv [6]  = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0};
		string   br_name [6] = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};
		ex_req_t req;
		word_t   x;
		word_t   y;
		logic    lt;
		begin_test();
		for (int b = 0; b < 6; b++) begin
			for (int p = 0; p < 3; p++) begin // Equal, less, greater
				req = random_req();
				x   = req.rs1_data;
				y   = req.rs2_data;
				if (x == y) y = ~x;
				lt  = (b < 4) ? ($signed(x) < $signed(y)) : (x < y);
				req.rs1_data = (p == 0) ? x : ((p == 1) == lt) ? x : y;
				req.rs2_data = (p == 0) ? x : ((p == 1) == lt) ? y : x;
				req.ctrl.op       = br_op[b];
				req.ctrl.branch   = 1'b1;
				req.ctrl.zero_inv = br_inv[b];
				send_req(br_name[b], req);
			end
		end
		repeat (3) begin
			req          = random_req();
			req.ctrl.jal = 1'b1;
			send_req("jal", req);
		end
		repeat (3) begin
			req              = random_req();
			req.ctrl.jalr    = 1'b1;
			req.ctrl.imm_sel = 1'b1;
			send_req("jalr", req);
		end
		end_test("branch");
	endtask

	task automatic mdu_case(input string name, input logic [2:0] op,
		input word_t a, input word_t b);
		ex_req_t req;
		req              = random_req();
		req.rs1_data     = a;
		req.rs2_data     = b;
		req.ctrl.op      = {1'b0, op};
		req.ctrl.mdu_sel = 1'b1;
		send_req(name, req);
	endtask

	task automatic mul_div_ops();
		word_t a;
		word_t b;
		begin_test();
		for (int op = 0; op < 8; op++) begin
			repeat (REPS) mdu_case("mdu_rand", 3'(op), rand_word(), rand_word());
		end
		mdu_case("div_zero", MDU_DIV, rand_word(), '0);
		mdu_case("divu_zero", MDU_DIVU, rand_word(), '0);
		mdu_case("rem_zero", MDU_REM, rand_word(), '0);
		mdu_case("remu_zero", MDU_REMU, rand_word(), '0);
		mdu_case("div_ovf", MDU_DIV, 32'h8000_0000, '1);
		mdu_case("rem_ovf", MDU_REM, 32'h8000_0000, '1);
		for (int s = 0; s < 4; s++) begin // All operand sign pairs
			a     = rand_word();
			b     = rand_word();
			a[31] = s[1];
			b[31] = s[0];
			mdu_case("mulh_sign", MDU_MULH, a, b);
			mdu_case("mulhsu_sign", MDU_MULHSU, a, b);
		end
		end_test("mdu");
	endtask

	initial begin
		clk_i      = 1'b0;
		arst_n_i   = 1'b0;
		req_i      = 1'b0;
		req_data_i = '0;
		ack_q      = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		#1 arst_n_i = 1'b1;
		begin_test();
		check_bit("reset ack", 1'b0, ack_o);
		end_test("reset");
		alu_reg_ops();
		imm_forms();
		branch_jump();
		mul_div_ops();
		if (exp_q.size() != 0) begin
			$display("%0d requests were never acknowledged", exp_q.size());
			fail_cnt++;
		end
		$display("checks %0d passed, %0d failed", pass_cnt, fail_cnt);
		if (fail_cnt == 0) $display("=== PASS ===");
		else $display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ex_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

// Execute unit top: immediate decode feeding the execute stage
module ex_unit import ex_types_pkg::*; (
	input  logic    clk_i,
	input  logic    arst_n_i,
	input  logic    req_i,      // Four-phase request
	input  ex_req_t req_data_i,
	output logic    ack_o,      // Four-phase acknowledge
	output ex_rsp_t rsp_o
);

	imm_set_t imm; // Combinational, follows the live instruction word

	//////////////////////
	// Immediates
	//////////////////////

	imm_gen imm_gen_inst (
		.instr_i (req_data_i.instr),
		.imm_o   (imm)
	);

	//////////////////////
	// Execute
	//////////////////////

	ex_stage ex_stage_inst (
		.clk_i      (clk_i),
		.arst_n_i   (arst_n_i),
		.req_i      (req_i),
		.req_data_i (req_data_i),
		.imm_i      (imm),
		.ack_o      (ack_o),
		.rsp_o      (rsp_o)
	);

endmodule

`default_nettype wire

// ==== ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

// Execute stage behind a four-phase req/ack link
module ex_stage import riscv_defines::*, ex_types_pkg::*; (
	input  logic     clk_i,
	input  logic     arst_n_i,
	input  logic     req_i,
	input  ex_req_t  req_data_i, // Stable while req_i is high
	input  imm_set_t imm_i,      // From imm_gen on req_data_i.instr
	output logic     ack_o,
	output ex_rsp_t  rsp_o       // Held while ack_o is high
);

	typedef enum logic [1:0] {IDLE, EXEC, MDU_WAIT, DONE} state_e;

	state_e   state_q;
	ex_req_t  req_q;    // Captured request
	imm_set_t imm_q;
	ex_rsp_t  rsp_q;
	ex_rsp_t  rsp_d;

	word_t lower_imm;
	word_t alu_imm;
	word_t pc_imm;
	word_t operand_a;
	word_t operand_b;
	word_t alu_result;
	word_t mdu_result;
	word_t ex_data;
	word_t pc_plus_four;
	logic  mdu_en;
	logic  mdu_start;
	logic  mdu_done;
	logic  zero_flag;
	logic  rsp_load;

	//////////////////////
	// Operand select
	//////////////////////

	always_comb begin
		lower_imm = req_q.ctrl.stype_imm_sel ? imm_q.s_imm : imm_q.i_imm;
		alu_imm   = req_q.ctrl.auipc ? imm_q.u_imm : lower_imm;
		operand_a = req_q.ctrl.auipc ? req_q.pc : req_q.rs1_data; // AUIPC adds to PC
		operand_b = req_q.ctrl.imm_sel ? alu_imm : req_q.rs2_data;
	end

	alu alu_inst (
		.operand_a_i (operand_a),
		.operand_b_i (operand_b),
		.operator_i  (alu_op_e'(req_q.ctrl.op)),
		.result_o    (alu_result)
	);

	assign mdu_en    = req_q.ctrl.mdu_sel && RISCV_M_CORE;
	assign mdu_start = (state_q == EXEC) && mdu_en; // Single pulse out of EXEC

	mdu mdu_inst (
		.clk_i       (clk_i),
		.arst_n_i    (arst_n_i),
		.start_i     (mdu_start),
		.operand_a_i (operand_a),
		.operand_b_i (operand_b),
		.operator_i  (mdu_op_e'(req_q.ctrl.op[2:0])),
		.done_o      (mdu_done),
		.result_o    (mdu_result)
	);

	//////////////////////
	// Response forming
	//////////////////////

	always_comb begin
		ex_data      = mdu_en ? mdu_result : alu_result;
		zero_flag    = (ex_data == '0);
		pc_plus_four = req_q.pc + word_t'(4);
		if (req_q.ctrl.jalr)     pc_imm = imm_q.i_imm;
		else if (req_q.ctrl.jal) pc_imm = imm_q.j_imm;
		else                     pc_imm = imm_q.b_imm;

		if (req_q.ctrl.lui_bypass)                     rsp_d.wb_data = imm_q.u_imm;
		else if (req_q.ctrl.jal || req_q.ctrl.jalr)   rsp_d.wb_data = pc_plus_four; // Link
		else                                           rsp_d.wb_data = ex_data;
		rsp_d.rd_addr      = req_q.instr[11:7];
		rsp_d.branch_addr  = req_q.pc + pc_imm;
		rsp_d.branch_taken = ((zero_flag ^ req_q.ctrl.zero_inv) && req_q.ctrl.branch)
			|| req_q.ctrl.jal || req_q.ctrl.jalr;
	end

	// ALU result ready in EXEC, MDU result only with its done pulse
	assign rsp_load = ((state_q == EXEC) && !mdu_en) || ((state_q == MDU_WAIT) && mdu_done);

	//////////////////////
	// Handshake FSM
	//////////////////////

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE;
		end else begin
			unique case (state_q)
				IDLE:     if (req_i) state_q <= EXEC;     // Capture edge
				EXEC:     state_q <= mdu_en ? MDU_WAIT : DONE;
				MDU_WAIT: if (mdu_done) state_q <= DONE;
				DONE:     if (!req_i) state_q <= IDLE;    // Return to zero
				default:  state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == IDLE && req_i) begin
			req_q <= req_data_i;
			imm_q <= imm_i;
		end
		if (rsp_load) rsp_q <= rsp_d;
	end

	assign ack_o = (state_q == DONE);
	assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// ==== mdu.sv ====
`timescale 1ns/1ps
`default_nettype none

// Iterative multiply/divide, one bit per cycle on magnitudes
module mdu import riscv_defines::*, ex_types_pkg::*; (
	input  logic    clk_i,
	input  logic    arst_n_i,
	input  logic    start_i,     // One-cycle pulse, operands valid with it
	input  word_t   operand_a_i, // Multiplicand or dividend
	input  word_t   operand_b_i, // Multiplier or divisor
	input  mdu_op_e operator_i,
	output logic    done_o,      // One-cycle pulse, result valid with it
	output word_t   result_o
);

	typedef enum logic [1:0] {IDLE, CALC, FIX} state_e;

	state_e                        state_q;
	logic [$clog2(MDU_CYCLES)-1:0] cnt_q;   // Step counter
	mdu_op_e                       op_q;
	word_t                         hi_q;    // Product high half, or partial remainder
	word_t                         lo_q;    // Multiplier/product low, or dividend/quotient
	word_t                         opr_q;   // Multiplicand or divisor magnitude
	logic                          a_neg_q;
	logic                          b_neg_q;
	logic                          b_zero_q;

	logic                    a_signed;
	logic                    b_signed;
	logic                    div_in;    // Incoming op is a divide
	logic                    div_q;     // Latched op is a divide
	logic                    last_step;
	word_t                   mag_a;
	word_t                   mag_b;
	logic [WORD_WIDTH:0]     mul_sum;   // Carry out of the add
	logic [WORD_WIDTH:0]     div_shift;
	logic [WORD_WIDTH:0]     div_diff;  // Top bit set when the trial fails
	logic [2*WORD_WIDTH-1:0] product;
	word_t                   quot;
	word_t                   rem;

	//////////////////////
	// Operand decode
	//////////////////////

	always_comb begin
		a_signed = operator_i inside {MDU_MULH, MDU_MULHSU, MDU_DIV, MDU_REM};
		b_signed = operator_i inside {MDU_MULH, MDU_DIV, MDU_REM};
		div_in   = operator_i inside {MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU};
		div_q    = op_q inside {MDU_DIV, MDU_DIVU, MDU_REM, MDU_REMU};
		mag_a    = (a_signed && operand_a_i[WORD_WIDTH-1]) ? -operand_a_i : operand_a_i;
		mag_b    = (b_signed && operand_b_i[WORD_WIDTH-1]) ? -operand_b_i : operand_b_i;
	end

	// Per-step arithmetic
	assign mul_sum   = {1'b0, hi_q} + (lo_q[0] ? {1'b0, opr_q} : '0);
	assign div_shift = {hi_q, lo_q[WORD_WIDTH-1]};    // Bring down next dividend bit
	assign div_diff  = div_shift - {1'b0, opr_q};
	assign last_step = (int'(cnt_q) == MDU_CYCLES - 1);

	//////////////////////
	// Control FSM
	//////////////////////

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE;
			cnt_q   <= '0;
		end else begin
			unique case (state_q)
				IDLE: begin
					cnt_q <= '0;
					if (start_i) state_q <= CALC;
				end
				CALC: begin
					cnt_q <= cnt_q + 1'b1;
					if (last_step) state_q <= FIX; // All bits processed
				end
				FIX:     state_q <= IDLE;          // Result presented for one cycle
				default: state_q <= IDLE;
			endcase
		end
	end

	// Datapath registers
	always_ff @(posedge clk_i) begin
		if (state_q == IDLE && start_i) begin
			op_q     <= operator_i;
			a_neg_q  <= a_signed && operand_a_i[WORD_WIDTH-1];
			b_neg_q  <= b_signed && operand_b_i[WORD_WIDTH-1];
			b_zero_q <= (operand_b_i == '0);
			hi_q     <= '0;
			lo_q     <= div_in ? mag_a : mag_b;
			opr_q    <= div_in ? mag_b : mag_a;
		end else if (state_q == CALC) begin
			if (div_q) begin
				if (!div_diff[WORD_WIDTH]) begin // Divisor fits, keep the difference
					hi_q <= div_diff[WORD_WIDTH-1:0];
					lo_q <= {lo_q[WORD_WIDTH-2:0], 1'b1};
				end else begin                   // Restore
					hi_q <= div_shift[WORD_WIDTH-1:0];
					lo_q <= {lo_q[WORD_WIDTH-2:0], 1'b0};
				end
			end else begin
				hi_q <= mul_sum[WORD_WIDTH:1];   // Add then shift right
				lo_q <= {mul_sum[0], lo_q[WORD_WIDTH-1:1]};
			end
		end
	end

	//////////////////////
	// Sign fix and select
	//////////////////////

	// Most negative / -1 falls out as 2^31 with a positive sign, i.e. the dividend
	always_comb begin
		product = {hi_q, lo_q};
		if (a_neg_q ^ b_neg_q) product = -product;
		quot = (a_neg_q ^ b_neg_q) ? -lo_q : lo_q;
		if (b_zero_q) quot = '1;                 // x/0 gives all ones
		rem  = a_neg_q ? -hi_q : hi_q;           // Remainder takes dividend sign; x%0 = x
		unique case (op_q)
			MDU_MUL:                          result_o = product[WORD_WIDTH-1:0];
			MDU_MULH, MDU_MULHSU, MDU_MULHU: result_o = product[2*WORD_WIDTH-1:WORD_WIDTH];
			MDU_DIV, MDU_DIVU:               result_o = quot;
			default:                          result_o = rem;
		endcase
	end

	assign done_o = (state_q == FIX);

endmodule

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

// RV32I arithmetic, logic, shift and compare
module alu import riscv_defines::*; (
	input  word_t   operand_a_i,
	input  word_t   operand_b_i,
	input  alu_op_e operator_i,
	output word_t   result_o
);

	logic [4:0] shamt;  // Only the low five bits shift
	word_t      sum;
	word_t      diff;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = operand_b_i[4:0];
	assign sum         = operand_a_i + operand_b_i;
	assign diff        = operand_a_i - operand_b_i;
	assign lt_signed   = $signed(operand_a_i) < $signed(operand_b_i);
	assign lt_unsigned = operand_a_i < operand_b_i;

	//////////////////////
	// Result select
	//////////////////////

	always_comb begin
		unique case (operator_i)
			ALU_ADD:  result_o = sum;
			ALU_SUB:  result_o = diff;                       // Zero when equal
			ALU_SLL:  result_o = operand_a_i << shamt;
			ALU_SLT:  result_o = {{(WORD_WIDTH-1){1'b0}}, lt_signed};   // 0 or 1
			ALU_SLTU: result_o = {{(WORD_WIDTH-1){1'b0}}, lt_unsigned}; // 0 or 1
			ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
			ALU_SRL:  result_o = operand_a_i >> shamt;
			ALU_SRA:  result_o = word_t'($signed(operand_a_i) >>> shamt); // Sign fill
			ALU_OR:   result_o = operand_a_i | operand_b_i;
			ALU_AND:  result_o = operand_a_i & operand_b_i;
			default:  result_o = sum; // Unused encodings fall back to add
		endcase
	end

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

// Immediate extraction for all RV32 formats
module imm_gen import riscv_defines::*, ex_types_pkg::*; (
	input  word_t    instr_i, // Raw instruction word
	output imm_set_t imm_o    // All five formats in parallel
);

	logic [11:0] i_raw;
	logic [11:0] s_raw;
	logic [19:0] u_raw;
	logic [12:0] b_raw;
	logic [20:0] j_raw;

	//////////////////////
	// Field slicing
	//////////////////////

	always_comb begin
		i_raw = instr_i[31:20];                                     // imm[11:0]
		s_raw = {instr_i[31:25], instr_i[11:7]};                    // Split around rs2
		u_raw = instr_i[31:12];                                     // Upper 20 bits
		b_raw = {instr_i[31], instr_i[7], instr_i[30:25],
			instr_i[11:8], 1'b0};                                   // Halfword aligned
		j_raw = {instr_i[31], instr_i[19:12], instr_i[20],
			instr_i[30:21], 1'b0};                                  // Halfword aligned
	end

	//////////////////////
	// Sign extension
	//////////////////////

	// Bit 31 of the instruction is the sign in every format
	always_comb begin
		imm_o.i_imm = {{20{i_raw[11]}}, i_raw};
		imm_o.s_imm = {{20{s_raw[11]}}, s_raw};
		imm_o.u_imm = {u_raw, 12'b0};           // Low bits zero
		imm_o.b_imm = {{19{b_raw[12]}}, b_raw};
		imm_o.j_imm = {{11{j_raw[20]}}, j_raw};
	end

endmodule

`default_nettype wire

// ==== ex_types_pkg.sv ====
`default_nettype none

// Execute-unit request/response bundles
package ex_types_pkg;

	import riscv_defines::*;

	// Iteration steps of the shift-add multiplier and restoring divider
	localparam int MDU_CYCLES = 32;

	//////////////////////
	// Control bundle
	//////////////////////

	// Decoder output that travels with each request
	typedef struct packed {
		logic [3:0] op;            // alu_op_e, or mdu_op_e in the low 3 bits
		logic       stype_imm_sel; // S immediate instead of I
		logic       auipc;         // PC as operand A, U immediate as operand B
		logic       imm_sel;       // Immediate as operand B
		logic       jalr;
		logic       jal;
		logic       branch;        // Conditional branch
		logic       lui_bypass;    // Write back the U immediate directly
		logic       zero_inv;      // Take branch on non-zero result
		logic       mdu_sel;       // Route through the multiply/divide unit
	} ex_ctrl_t;

	//////////////////////
	// Link payloads
	//////////////////////

	typedef struct packed {
		word_t    rs1_data;
		word_t    rs2_data;
		word_t    instr;    // Raw instruction word
		word_t    pc;
		ex_ctrl_t ctrl;
	} ex_req_t;

	typedef struct packed {
		word_t     wb_data;      // Register write-back value
		reg_addr_t rd_addr;
		word_t     branch_addr;  // Redirect target
		logic      branch_taken; // Redirect request
	} ex_rsp_t;

	// Every immediate format, already sign-extended
	typedef struct packed {
		word_t i_imm;
		word_t s_imm;
		word_t u_imm;
		word_t b_imm;
		word_t j_imm;
	} imm_set_t;

endpackage

`default_nettype wire

// ==== riscv_defines.sv ====
`default_nettype none

// ISA-level widths, base types and operation encodings
package riscv_defines;

	//////////////////////
	// Widths
	//////////////////////

	localparam int WORD_WIDTH   = 32;   // RV32 data word
	localparam int ADDR_WIDTH   = 5;    // x0..x31
	localparam bit RISCV_M_CORE = 1'b1; // Multiply/divide extension present

	typedef logic [WORD_WIDTH-1:0] word_t;     // Register value, PC, immediate
	typedef logic [ADDR_WIDTH-1:0] reg_addr_t; // rs1/rs2/rd index

	//////////////////////
	// Operations
	//////////////////////

	// ALU operations as driven by the decoder
	typedef enum logic [3:0] {
		ALU_ADD  = 4'h0, // Also address and AUIPC sums
		ALU_SUB  = 4'h1, // BEQ/BNE compare through the zero flag
		ALU_SLL  = 4'h2,
		ALU_SLT  = 4'h3, // BLT/BGE
		ALU_SLTU = 4'h4, // BLTU/BGEU
		ALU_XOR  = 4'h5,
		ALU_SRL  = 4'h6,
		ALU_SRA  = 4'h7,
		ALU_OR   = 4'h8,
		ALU_AND  = 4'h9
	} alu_op_e;

	// M extension operations, same order as funct3
	typedef enum logic [2:0] {
		MDU_MUL    = 3'h0, // Low word of the product
		MDU_MULH   = 3'h1, // High word, signed x signed
		MDU_MULHSU = 3'h2, // High word, signed x unsigned
		MDU_MULHU  = 3'h3, // High word, unsigned x unsigned
		MDU_DIV    = 3'h4,
		MDU_DIVU   = 3'h5,
		MDU_REM    = 3'h6,
		MDU_REMU   = 3'h7
	} mdu_op_e;

endpackage

`default_nettype wire
